// ==== hdl/ccu_pkg.sv ====
`default_nettype none

package ccu_pkg;

    // ==================================================================
    // Instruction word layout
    // ==================================================================
    localparam int OPCODE_W = 8;       // Opcode in low bits of every word

    localparam int NUM_REQ = 3;        // CCU, KNN, SYA

    // Requester index, equal to the opcode value
    typedef logic [1:0] req_id_t;

    // Lower index wins arbitration
    localparam req_id_t OP_CCU = 2'd0;
    localparam req_id_t OP_KNN = 2'd1;
    localparam req_id_t OP_SYA = 2'd2;

    // Words per configuration
    localparam int NUM_WORDS_CCU = 1;
    localparam int NUM_WORDS_KNN = 1;
    localparam int NUM_WORDS_SYA = 2;

    // ==================================================================
    // Field widths
    // ==================================================================
    localparam int IDX_W   = 16;       // Point index
    localparam int CHN_W   = 12;       // Channel count
    localparam int ACT_W   = 8;        // Activation quantization
    localparam int LAYER_W = 20;       // Layer count
    localparam int K_W     = 6;        // Neighbours per point
    localparam int BASE_W  = 16;       // Buffer base addresses

    // ==================================================================
    // Engine configurations
    // ==================================================================
    typedef struct packed {
        logic [IDX_W-1:0] nip;          // Input points
        logic [K_W-1:0]   k;
        logic [IDX_W-1:0] crd_rd_addr;  // Coordinate read base
        logic [IDX_W-1:0] map_wr_addr;  // Neighbour map write base
    } knn_cfg_t;

    typedef struct packed {
        // Word 0
        logic [ACT_W-1:0]  shift;
        logic [ACT_W-1:0]  zp;
        logic [1:0]        mode;
        logic              ofm_phase_shift;
        logic [CHN_W-1:0]  chn;
        logic [IDX_W-1:0]  grp_per_tile;
        logic [IDX_W-1:0]  num_til_ifm;
        logic [IDX_W-1:0]  num_til_flt;
        logic              loop_ord;
        // Word 1
        logic [BASE_W-1:0] act_base;
        logic [BASE_W-1:0] wgt_base;
        logic [BASE_W-1:0] ofm_base;
    } sya_cfg_t;

endpackage

`default_nettype wire

// ==== hdl/cfg_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_port #(
    parameter type PAYLOAD_T = logic [7:0]
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic load_i,
    input  PAYLOAD_T  payload_i,
    output PAYLOAD_T  cfg_o,
    output logic      cfg_vld_o,
    input  wire logic cfg_rdy_i
);

    PAYLOAD_T cfg_q;
    logic     vld_q;

    // Payload only changes on load, so it is stable while valid waits
    always_ff @(posedge clk) begin
        if (load_i) cfg_q <= payload_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else if (load_i) begin
            vld_q <= 1'b1;
        end else if (vld_q && cfg_rdy_i) begin
            vld_q <= 1'b0;   // Engine took it
        end
    end

    assign cfg_o     = cfg_q;
    assign cfg_vld_o = vld_q;

endmodule

`default_nettype wire

// ==== hdl/ccu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ccu_ctrl (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         start_i,
    input  wire logic [ccu_pkg::NUM_REQ-2:0]  rdy_i,        // Engine readies, KNN in bit 0
    input  wire logic [1:0]                   port_vld_i,   // Config port valids
    input  wire logic                         cfg_done_i,
    input  wire logic [ccu_pkg::LAYER_W-1:0]  num_layers_i,
    output ccu_pkg::req_id_t                  sel_o,
    output logic                              fetch_en_o,
    output logic                              clear_o,
    output logic                              net_done_o,
    output logic                              eng_rst_o
);
    import ccu_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        ARB,
        FETCH,
        ISSUE,
        NETFNH
    } state_t;

    state_t               state_q, state_d;
    req_id_t              sel_q;
    req_id_t              grant;
    logic [NUM_REQ-1:0]   req;
    logic                 ccu_rdy_q;
    logic [LAYER_W-1:0]   num_layers_q;
    logic [LAYER_W-1:0]   layer_cnt_q;
    logic [LAYER_W-1:0]   layer_nxt;
    logic                 port_busy;

    // ==================================================================
    // Fixed priority arbiter
    // ==================================================================
    assign req = {rdy_i, ccu_rdy_q};

    always_comb begin
        grant = OP_CCU;
        for (int i = NUM_REQ - 1; i >= 0; i--) begin
            if (req[i]) grant = req_id_t'(i);   // Lowest set index wins
        end
    end

    assign port_busy = port_vld_i[sel_q == OP_SYA];
    assign layer_nxt = layer_cnt_q + LAYER_W'(1);

    // ==================================================================
    // FSM
    // ==================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:   if (start_i) state_d = ARB;
            ARB:    if (|req) state_d = FETCH;
            FETCH: begin
                if (cfg_done_i) state_d = (sel_q == OP_CCU) ? ARB : ISSUE;
            end
            ISSUE: begin
                // Leave once the engine has taken its config
                if (!port_busy) begin
                    if (layer_nxt == num_layers_q && num_layers_q != '0) state_d = NETFNH;
                    else state_d = ARB;
                end
            end
            NETFNH: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            sel_q        <= OP_CCU;
            ccu_rdy_q    <= 1'b1;
            num_layers_q <= '0;
            layer_cnt_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ARB && |req) sel_q <= grant;   // Latch the winner
            if (state_q == IDLE) begin
                ccu_rdy_q   <= 1'b1;
                layer_cnt_q <= '0;
            end else if (cfg_done_i && sel_q == OP_CCU) begin
                ccu_rdy_q    <= 1'b0;
                num_layers_q <= num_layers_i;
            end
            if (state_q == ISSUE && !port_busy) layer_cnt_q <= layer_nxt;
        end
    end

    assign sel_o      = sel_q;
    assign fetch_en_o = (state_q == FETCH);
    assign clear_o    = (state_q == IDLE);
    assign net_done_o = (state_q == NETFNH);
    assign eng_rst_o  = (state_q == IDLE);

endmodule

`default_nettype wire

// ==== hdl/isa_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module isa_fetch #(
    parameter int WORD_W = 128,
    parameter int ADDR_W = 12
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              clear_i,
    input  wire logic              fetch_en_i,
    input  ccu_pkg::req_id_t       sel_i,
    // Instruction memory address channel
    output logic [ADDR_W-1:0]      isa_addr_o,
    output logic                   isa_addr_vld_o,
    input  wire logic              isa_addr_rdy_i,
    // Instruction memory data channel
    input  wire logic [WORD_W-1:0] isa_dat_i,
    input  wire logic              isa_dat_vld_i,
    output logic                   isa_dat_rdy_o,
    // To decode
    output logic [WORD_W-1:0]      word_o,
    output logic                   word_vld_o
);
    import ccu_pkg::*;

    logic [ADDR_W-1:0] ptr_q [NUM_REQ];   // One read pointer per requester
    logic              pend_q;            // Read outstanding
    logic              addr_hs;
    logic              dat_hs;

    // ==================================================================
    // Address side
    // ==================================================================
    // Only one read in flight, so no address while waiting for data
    assign isa_addr_vld_o = fetch_en_i & ~pend_q;
    assign isa_addr_o     = ptr_q[sel_i];
    assign addr_hs        = isa_addr_vld_o & isa_addr_rdy_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REQ; i++) begin
                ptr_q[i] <= '0;
            end
        end else if (clear_i) begin
            for (int i = 0; i < NUM_REQ; i++) begin
                ptr_q[i] <= '0;
            end
        end else if (addr_hs) begin
            ptr_q[sel_i] <= ptr_q[sel_i] + ADDR_W'(1);
        end
    end

    // ==================================================================
    // Data side
    // ==================================================================
    assign isa_dat_rdy_o = pend_q;
    assign dat_hs        = isa_dat_vld_i & pend_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
        end else if (addr_hs) begin
            pend_q <= 1'b1;
        end else if (dat_hs) begin
            pend_q <= 1'b0;
        end
    end

    // Word goes to decode in the handshake cycle
    assign word_o     = isa_dat_i;
    assign word_vld_o = dat_hs;

endmodule

`default_nettype wire

// ==== hdl/isa_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module isa_decode #(
    parameter int WORD_W = 128
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  ccu_pkg::req_id_t                 sel_i,
    input  wire logic [WORD_W-1:0]           word_i,
    input  wire logic                        word_vld_i,
    output logic                             cfg_done_o,
    output logic [ccu_pkg::LAYER_W-1:0]      num_layers_o,
    output logic                             knn_load_o,
    output ccu_pkg::knn_cfg_t                knn_cfg_o,
    output logic                             sya_load_o,
    output ccu_pkg::sya_cfg_t                sya_cfg_o
);
    import ccu_pkg::*;

    // ==================================================================
    // Field offsets inside a word
    // ==================================================================
    localparam int KNN_K   = OPCODE_W + IDX_W;
    localparam int KNN_CRD = KNN_K + K_W;
    localparam int KNN_MAP = KNN_CRD + IDX_W;

    localparam int SYA_ZP  = OPCODE_W + ACT_W;
    localparam int SYA_MOD = SYA_ZP + ACT_W;
    localparam int SYA_PHS = SYA_MOD + 2;
    localparam int SYA_CHN = SYA_PHS + 1;
    localparam int SYA_GRP = SYA_CHN + CHN_W;
    localparam int SYA_TIF = SYA_GRP + IDX_W;
    localparam int SYA_TFL = SYA_TIF + IDX_W;
    localparam int SYA_LOP = SYA_TFL + IDX_W;
    localparam int SYA_WGT = OPCODE_W + BASE_W;
    localparam int SYA_OFM = SYA_WGT + BASE_W;

    logic [1:0] widx_q;          // Word index within the config
    logic [1:0] last_idx;
    logic       match;
    logic       last;
    sya_cfg_t   sya_asm_q;       // Word 0 fields held for word 1
    sya_cfg_t   sya_nxt;

    always_comb begin
        case (sel_i)
            OP_KNN:  last_idx = 2'(NUM_WORDS_KNN - 1);
            OP_SYA:  last_idx = 2'(NUM_WORDS_SYA - 1);
            default: last_idx = 2'(NUM_WORDS_CCU - 1);
        endcase
    end

    // Words of other engines pass by unused
    assign match      = word_vld_i && (word_i[OPCODE_W-1:0] == OPCODE_W'(sel_i));
    assign last       = (widx_q == last_idx);
    assign cfg_done_o = match & last;
    assign knn_load_o = cfg_done_o && (sel_i == OP_KNN);
    assign sya_load_o = cfg_done_o && (sel_i == OP_SYA);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            widx_q <= '0;
        end else if (match) begin
            widx_q <= last ? 2'd0 : widx_q + 2'd1;
        end
    end

    // ==================================================================
    // Field unpacking
    // ==================================================================
    assign num_layers_o = word_i[OPCODE_W +: LAYER_W];

    always_comb begin
        knn_cfg_o.nip         = word_i[OPCODE_W +: IDX_W];
        knn_cfg_o.k           = word_i[KNN_K +: K_W];
        knn_cfg_o.crd_rd_addr = word_i[KNN_CRD +: IDX_W];
        knn_cfg_o.map_wr_addr = word_i[KNN_MAP +: IDX_W];
    end

    always_comb begin
        sya_nxt = sya_asm_q;
        if (widx_q == 2'd0) begin
            sya_nxt.shift           = word_i[OPCODE_W +: ACT_W];
            sya_nxt.zp              = word_i[SYA_ZP +: ACT_W];
            sya_nxt.mode            = word_i[SYA_MOD +: 2];
            sya_nxt.ofm_phase_shift = word_i[SYA_PHS];
            sya_nxt.chn             = word_i[SYA_CHN +: CHN_W];
            sya_nxt.grp_per_tile    = word_i[SYA_GRP +: IDX_W];
            sya_nxt.num_til_ifm     = word_i[SYA_TIF +: IDX_W];
            sya_nxt.num_til_flt     = word_i[SYA_TFL +: IDX_W];
            sya_nxt.loop_ord        = word_i[SYA_LOP];
        end else begin
            sya_nxt.act_base = word_i[OPCODE_W +: BASE_W];
            sya_nxt.wgt_base = word_i[SYA_WGT +: BASE_W];
            sya_nxt.ofm_base = word_i[SYA_OFM +: BASE_W];
        end
    end

    always_ff @(posedge clk) begin
        if (match && sel_i == OP_SYA) sya_asm_q <= sya_nxt;
    end

    assign sya_cfg_o = sya_nxt;   // Complete when the last word arrives

endmodule

`default_nettype wire

// ==== hdl/ccu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ccu_top #(
    parameter int WORD_W = 128,
    parameter int ADDR_W = 12
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              start_i,
    output logic                   net_done_o,
    output logic                   eng_rst_o,
    // Instruction memory
    output logic [ADDR_W-1:0]      isa_addr_o,
    output logic                   isa_addr_vld_o,
    input  wire logic              isa_addr_rdy_i,
    input  wire logic [WORD_W-1:0] isa_dat_i,
    input  wire logic              isa_dat_vld_i,
    output logic                   isa_dat_rdy_o,
    // KNN engine
    output ccu_pkg::knn_cfg_t      knn_cfg_o,
    output logic                   knn_cfg_vld_o,
    input  wire logic              knn_cfg_rdy_i,
    // Systolic array
    output ccu_pkg::sya_cfg_t      sya_cfg_o,
    output logic                   sya_cfg_vld_o,
    input  wire logic              sya_cfg_rdy_i
);
    import ccu_pkg::*;

    req_id_t             sel;
    logic                fetch_en;
    logic                clear;
    logic [WORD_W-1:0]   word;
    logic                word_vld;
    logic                cfg_done;
    logic [LAYER_W-1:0]  num_layers;
    logic                knn_load;
    logic                sya_load;
    knn_cfg_t            knn_payload;
    sya_cfg_t            sya_payload;

    // ==================================================================
    // Control
    // ==================================================================
    ccu_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .rdy_i        ({sya_cfg_rdy_i, knn_cfg_rdy_i}),
        .port_vld_i   ({sya_cfg_vld_o, knn_cfg_vld_o}),
        .cfg_done_i   (cfg_done),
        .num_layers_i (num_layers),
        .sel_o        (sel),
        .fetch_en_o   (fetch_en),
        .clear_o      (clear),
        .net_done_o   (net_done_o),
        .eng_rst_o    (eng_rst_o)
    );

    // ==================================================================
    // Instruction path
    // ==================================================================
    isa_fetch #(.WORD_W(WORD_W), .ADDR_W(ADDR_W)) u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .clear_i        (clear),
        .fetch_en_i     (fetch_en),
        .sel_i          (sel),
        .isa_addr_o     (isa_addr_o),
        .isa_addr_vld_o (isa_addr_vld_o),
        .isa_addr_rdy_i (isa_addr_rdy_i),
        .isa_dat_i      (isa_dat_i),
        .isa_dat_vld_i  (isa_dat_vld_i),
        .isa_dat_rdy_o  (isa_dat_rdy_o),
        .word_o         (word),
        .word_vld_o     (word_vld)
    );

    isa_decode #(.WORD_W(WORD_W)) u_decode (
        .clk (clk), .rst_n (rst_n), .sel_i (sel), .word_i (word),
        .word_vld_i (word_vld), .cfg_done_o (cfg_done), .num_layers_o (num_layers),
        .knn_load_o (knn_load), .knn_cfg_o (knn_payload),
        .sya_load_o (sya_load), .sya_cfg_o (sya_payload)
    );

    // ==================================================================
    // Engine config ports
    // ==================================================================
    cfg_port #(.PAYLOAD_T(knn_cfg_t)) u_knn_port (
        .clk (clk), .rst_n (rst_n), .load_i (knn_load), .payload_i (knn_payload),
        .cfg_o (knn_cfg_o), .cfg_vld_o (knn_cfg_vld_o), .cfg_rdy_i (knn_cfg_rdy_i)
    );

    cfg_port #(.PAYLOAD_T(sya_cfg_t)) u_sya_port (
        .clk (clk), .rst_n (rst_n), .load_i (sya_load), .payload_i (sya_payload),
        .cfg_o (sya_cfg_o), .cfg_vld_o (sya_cfg_vld_o), .cfg_rdy_i (sya_cfg_rdy_i)
    );

endmodule

`default_nettype wire

// ==== tb/ccu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ccu_checker (
    input wire logic        clk,
    input wire logic        rst_n,
    input wire logic        isa_addr_vld_o,
    input wire logic        isa_dat_rdy_o,
    input wire logic        net_done_o,
    input ccu_pkg::knn_cfg_t knn_cfg_o,
    input wire logic        knn_cfg_vld_o,
    input wire logic        knn_cfg_rdy_i,
    input ccu_pkg::sya_cfg_t sya_cfg_o,
    input wire logic        sya_cfg_vld_o,
    input wire logic        sya_cfg_rdy_i
);

    int one_read_err = 0;    // Failures per assertion
    int knn_hold_err = 0;
    int sya_hold_err = 0;
    int pulse_err    = 0;

    // Single outstanding read
    one_read_a: assert property (@(posedge clk) disable iff (!rst_n)
        isa_dat_rdy_o |-> !isa_addr_vld_o)
        else begin
            $error("address valid while a read is outstanding");
            one_read_err++;
        end

    knn_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        knn_cfg_vld_o && !knn_cfg_rdy_i |=> knn_cfg_vld_o && $stable(knn_cfg_o))
        else begin
            $error("KNN config changed before it was taken");
            knn_hold_err++;
        end

    sya_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        sya_cfg_vld_o && !sya_cfg_rdy_i |=> sya_cfg_vld_o && $stable(sya_cfg_o))
        else begin
            $error("systolic array config changed before it was taken");
            sya_hold_err++;
        end

    pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        net_done_o |=> !net_done_o)
        else begin
            $error("net_done_o is wider than one cycle");
            pulse_err++;
        end

endmodule

`default_nettype wire

// ==== tb/tb_ccu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ccu;
    import ccu_pkg::*;

    localparam int WORD_W = 128;
    localparam int ADDR_W = 12;
    localparam int KNN_BASE = 17;   // First expected KNN line in the trace

    logic              clk = 1'b0;
    logic              rst_n = 1'b0;
    logic              start_i = 1'b0;
    logic              net_done_o;
    logic              eng_rst_o;
    logic [ADDR_W-1:0] isa_addr_o;
    logic              isa_addr_vld_o;
    logic              isa_addr_rdy_i = 1'b0;
    logic [WORD_W-1:0] isa_dat_i = '0;
    logic              isa_dat_vld_i = 1'b0;
    logic              isa_dat_rdy_o;
    knn_cfg_t          knn_cfg_o;
    logic              knn_cfg_vld_o;
    logic              knn_cfg_rdy_i = 1'b0;
    sya_cfg_t          sya_cfg_o;
    logic              sya_cfg_vld_o;
    logic              sya_cfg_rdy_i = 1'b0;

    logic [191:0]      trace_q [0:31];
    logic [WORD_W-1:0] imem [0:4095];
    int                seed = 47978;
    int                layers;
    int                nknn;
    int                nsya;
    int                knn_taken = 0;
    int                sya_taken = 0;
    int                net_cnt = 0;
    int                err_val = 0;
    int                err_other = 0;
    int                err_main = 0;
    logic              rd_pend = 1'b0;
    logic [ADDR_W-1:0] rd_addr = '0;
    logic [1:0]        rd_lat = '0;

    ccu_top #(.WORD_W(WORD_W), .ADDR_W(ADDR_W)) dut_i (.*);

    bind ccu_top ccu_checker u_checker (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    // ==================================================================
    // Expected configs from the trace slots
    // ==================================================================
    function automatic knn_cfg_t knn_from_trace(input logic [191:0] l);
        knn_cfg_t e;
        e.nip         = l[63:48];
        e.k           = l[37:32];
        e.crd_rd_addr = l[31:16];
        e.map_wr_addr = l[15:0];
        return e;
    endfunction

    function automatic sya_cfg_t sya_from_trace(input logic [191:0] l);
        sya_cfg_t e;
        e.shift           = l[183:176];
        e.zp              = l[167:160];
        e.mode            = l[145:144];
        e.ofm_phase_shift = l[128];
        e.chn             = l[123:112];
        e.grp_per_tile    = l[111:96];
        e.num_til_ifm     = l[95:80];
        e.num_til_flt     = l[79:64];
        e.loop_ord        = l[48];
        e.act_base        = l[47:32];
        e.wgt_base        = l[31:16];
        e.ofm_base        = l[15:0];
        return e;
    endfunction

    task automatic load_trace;
        int nwords;
        $readmemh("tb/isa_trace.txt", trace_q);
        layers = 32'(trace_q[16][63:48]);
        nwords = 32'(trace_q[16][47:32]);
        nknn   = 32'(trace_q[16][31:16]);
        nsya   = 32'(trace_q[16][15:0]);
        for (int i = 0; i < 4096; i++) begin
            imem[i] = {20'(i), 100'h0, 8'hff};   // Opcode ff never matches
        end
        for (int i = 0; i < nwords; i++) begin
            imem[i] = trace_q[i][127:0];
        end
    endtask

    // ==================================================================
    // Memory model and engines, driven on the falling edge
    // ==================================================================
    // DUT valids are all registered, so a handshake is known here
    always @(negedge clk) begin : drive_blk
        int r;
        r = $random(seed);
        isa_dat_vld_i = 1'b0;
        if (rd_pend) begin
            if (rd_lat == 2'd0) begin
                assert (isa_dat_rdy_o) else begin
                    $display("data ready is low while a read is outstanding at %0t", $time);
                    err_other++;
                end
                isa_dat_vld_i = 1'b1;
                isa_dat_i     = imem[rd_addr];
                rd_pend       = 1'b0;
            end else begin
                rd_lat = rd_lat - 2'd1;
            end
        end
        isa_addr_rdy_i = r[0];
        if (isa_addr_vld_o && r[0]) begin
            rd_pend = 1'b1;
            rd_addr = isa_addr_o;
            rd_lat  = r[2:1];   // 0 to 3 cycles to data
        end

        // Engines go idle once their expected configs are used up
        // and toggle again once the network is done
        knn_cfg_rdy_i = (knn_taken < nknn || net_cnt != 0) ? r[3] : 1'b0;
        sya_cfg_rdy_i = (sya_taken < nsya || net_cnt != 0) ? r[4] : 1'b0;
        if (knn_cfg_vld_o && knn_cfg_rdy_i) begin
            assert (knn_cfg_o == knn_from_trace(trace_q[KNN_BASE + knn_taken])) else begin
                $display("FAIL t=%0t knn_cfg_o expected %h got %h", $time,
                         knn_from_trace(trace_q[KNN_BASE + knn_taken]), knn_cfg_o);
                err_val++;
            end
            knn_taken++;
        end
        if (sya_cfg_vld_o && sya_cfg_rdy_i) begin
            assert (sya_cfg_o == sya_from_trace(trace_q[KNN_BASE + nknn + sya_taken])) else begin
                $display("FAIL t=%0t sya_cfg_o expected %h got %h", $time,
                         sya_from_trace(trace_q[KNN_BASE + nknn + sya_taken]), sya_cfg_o);
                err_val++;
            end
            sya_taken++;
        end
        if (net_done_o) begin
            net_cnt++;
            assert (knn_taken + sya_taken == layers) else begin
                $display("FAIL t=%0t configs_taken expected %0d got %0d", $time,
                         layers, knn_taken + sya_taken);
                err_val++;
            end
        end
    end

    task automatic wait_net_done(output logic ok);
        ok = 1'b0;
        for (int n = 0; n < 5000 && !ok; n++) begin
            @(negedge clk);
            if (net_done_o) ok = 1'b1;
        end
        if (!ok) $display("timed out waiting for net_done_o");
    endtask

    task automatic wait_eng_rst(output logic ok);
        ok = 1'b0;
        for (int n = 0; n < 20 && !ok; n++) begin
            @(negedge clk);
            if (eng_rst_o) ok = 1'b1;
        end
        if (!ok) $display("timed out waiting for eng_rst_o after net_done_o");
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        logic ok;
        int   chk;
        int   total;
        load_trace();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;

        wait_net_done(ok);
        if (ok) wait_eng_rst(ok);
        if (ok) begin
            // Nothing more may be issued once the network is done
            for (int n = 0; n < 30; n++) begin
                @(negedge clk);
                assert (!knn_cfg_vld_o && !sya_cfg_vld_o && eng_rst_o) else begin
                    $display("engine valid rose or engine reset dropped after done at %0t",
                             $time);
                    err_main++;
                end
            end
            assert (knn_taken == nknn) else begin
                $display("FAIL t=%0t knn_taken expected %0d got %0d", $time, nknn, knn_taken);
                err_main++;
            end
            assert (sya_taken == nsya) else begin
                $display("FAIL t=%0t sya_taken expected %0d got %0d", $time, nsya, sya_taken);
                err_main++;
            end
            assert (net_cnt == 1) else begin
                $display("FAIL t=%0t net_done_o pulses expected 1 got %0d", $time, net_cnt);
                err_main++;
            end
        end

        chk = dut_i.u_checker.one_read_err + dut_i.u_checker.knn_hold_err
            + dut_i.u_checker.sya_hold_err + dut_i.u_checker.pulse_err;
        total = err_val + err_other + err_main + chk;
        $display("errors: value %0d, protocol %0d, end of run %0d, checker %0d",
                 err_val, err_other, err_main, chk);
        if (!ok || total != 0) begin
            $display("RESULT: FAIL");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/isa_trace.txt ====
// Columns: one hex value per line; 0x00-0x0f instruction words, 0x10 header
// Header slots of 16 bits: layers, memory words, KNN configs, SYA configs
@00
00000000000000000200010010020001
00000000008001000100010105800402
00000000000000000000000000000400
00000000000000000030002000100002
0000000000000000000800043f004001
0000000000000000deadbeef00000003
00000000000004000300020202221102
0000000000000000001230def0abc02
@10
0004000800020002
// KNN expected, 16-bit slots: nip, k, crd_rd_addr, map_wr_addr
@11
0200001004000800
0040003f00100020
// SYA expected, 16-bit slots: shift, zp, mode, phase, chn, grp, tiles ifm,
// tiles flt, loop order, act base, wgt base, ofm base
@13
000400800001000100200002000200020001100020003000
0011002200020000004000040006000800000abc0def0123

// ==== filelist.f ====
hdl/ccu_pkg.sv
hdl/cfg_port.sv
hdl/ccu_ctrl.sv
hdl/isa_fetch.sv
hdl/isa_decode.sv
hdl/ccu_top.sv
tb/ccu_checker.sv
tb/tb_ccu.sv

// ==== run.sh ====
#!/bin/bash
# Build with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_ccu \
    -f filelist.f -o vsim_ccu \
    && { ./obj_dir/vsim_ccu +verilator+error+limit+1000 | tee /dev/stderr \
        | grep -q "^RESULT: PASS$"; } \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
